// ==== design/tlp_tx_settings.svh ====
// Widths and counts shared by the TLP transmit package, RTL and bench.
// Include this file wherever one of these macros is used.
`ifndef TLP_TX_SETTINGS_SVH
`define TLP_TX_SETTINGS_SVH

// stream word width
`define TLP_TX_DATA_W 32

// transmit sequence number width
`define TLP_TX_SEQ_W 12

// flow-control counter widths
`define TLP_TX_HDR_CRED_W 8
`define TLP_TX_DATA_CRED_W 12

// posted, non-posted, completion
`define TLP_TX_NUM_CLASSES 3

// LCRC polynomial and seed
`define TLP_TX_LCRC_POLY 32'h04C11DB7
`define TLP_TX_LCRC_INIT 32'hFFFFFFFF

`endif

// ==== design/tlp_tx_pkg.sv ====
// Types shared across the TLP transmit datapath.
// Referenced with scoped names from the RTL and the bench.
`include "tlp_tx_settings.svh"

package tlp_tx_pkg;

  // beat on the TLP input stream
  typedef struct packed {
    logic                       last;
    logic [`TLP_TX_DATA_W-1:0]  data;
  } tlp_beat_t;

  // beat on the link output stream
  typedef struct packed {
    logic                       sop;
    logic                       eop;
    logic [`TLP_TX_DATA_W-1:0]  data;
  } link_beat_t;

  // first header DW, reserved bits pass through untouched
  typedef struct packed {
    logic [2:0]   fmt;
    logic [4:0]   typ;
    logic [13:0]  rsvd;
    logic [9:0]   length;
  } tlp_hdr_dw0_t;

  typedef enum logic [1:0] {
    POSTED     = 2'd0,
    NONPOSTED  = 2'd1,
    COMPLETION = 2'd2
  } credit_class_e;

  // credits one TLP draws from its class
  typedef struct packed {
    credit_class_e                  cls;
    logic [`TLP_TX_HDR_CRED_W-1:0]  hdr_need;
    logic [`TLP_TX_DATA_CRED_W-1:0] data_need;
  } credit_req_t;

  // limits advertised by the link partner for one class
  typedef struct packed {
    logic [`TLP_TX_HDR_CRED_W-1:0]  hdr_limit;
    logic [`TLP_TX_DATA_CRED_W-1:0] data_limit;
  } fc_limit_t;

  // all classes, indexed by credit_class_e
  typedef fc_limit_t [`TLP_TX_NUM_CLASSES-1:0] fc_update_t;

endpackage

// ==== design/beat_skid.sv ====
// Two-entry skid buffer for a valid/ready stream of any beat type.
// Ready is registered so a chain of these keeps full throughput.
`timescale 1ns/10ps

module beat_skid #(
  parameter type beat_t = logic
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  beat_t in_beat_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,
  output beat_t out_beat_o,
  output logic  out_valid_o,
  input  logic  out_ready_i
);

  beat_t main_beat;
  beat_t skid_beat;
  logic  main_valid;
  logic  skid_valid;
  logic  in_fire;
  logic  main_free;

  assign in_ready_o  = !skid_valid;
  assign in_fire     = in_valid_i && in_ready_o;
  // main slot empties or drains this cycle
  assign main_free   = !main_valid || out_ready_i;
  assign out_beat_o  = main_beat;
  assign out_valid_o = main_valid;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_free) begin
      main_valid <= skid_valid || in_fire;
      skid_valid <= 1'b0;
    end else if (in_fire) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (main_free) begin
      main_beat <= skid_valid ? skid_beat : in_beat_i;
    end
    if (!main_free && in_fire) begin
      skid_beat <= in_beat_i;
    end
  end

  // a stalled beat is held until taken
  a_out_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_beat_o));

endmodule

// ==== design/tlp_classifier.sv ====
// Decodes the first TLP header word into its flow-control class
// and the header and data credits the TLP needs.
`timescale 1ns/10ps
`include "tlp_tx_settings.svh"

module tlp_classifier (
  input  tlp_tx_pkg::tlp_hdr_dw0_t head_word_i,
  output tlp_tx_pkg::credit_req_t  req_o
);

  logic        has_data;
  logic [10:0] len_round;

  // fmt bit 1 marks a TLP with payload
  assign has_data  = head_word_i.fmt[1];
  assign len_round = {1'b0, head_word_i.length} + 11'd3;

  always_comb begin
    req_o.hdr_need = {{(`TLP_TX_HDR_CRED_W-1){1'b0}}, 1'b1};

    if (head_word_i.typ == 5'b01010) begin
      req_o.cls = tlp_tx_pkg::COMPLETION;
    end else if (head_word_i.typ[4:3] == 2'b10) begin
      // messages
      req_o.cls = tlp_tx_pkg::POSTED;
    end else if (head_word_i.typ == 5'b00000 && has_data) begin
      // memory write
      req_o.cls = tlp_tx_pkg::POSTED;
    end else begin
      req_o.cls = tlp_tx_pkg::NONPOSTED;
    end

    // one data credit per 4 DW, rounded up
    if (!has_data) begin
      req_o.data_need = '0;
    end else if (head_word_i.length == 10'd0) begin
      // length 0 encodes 1024 DW
      req_o.data_need = {{(`TLP_TX_DATA_CRED_W-9){1'b0}}, 9'h100};
    end else begin
      req_o.data_need = {{(`TLP_TX_DATA_CRED_W-9){1'b0}}, len_round[10:2]};
    end
  end

endmodule

// ==== design/credit_gate.sv ====
// Flow-control credit tracking for one class.
// Holds the advertised limits and consumed counts and grants a request
// of its own class once both header and data credit are available.
`timescale 1ns/10ps
`include "tlp_tx_settings.svh"

module credit_gate (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  tlp_tx_pkg::credit_class_e  class_id_i,
  input  tlp_tx_pkg::credit_req_t    req_i,
  input  tlp_tx_pkg::fc_limit_t      limit_i,
  input  logic                       limit_valid_i,
  input  logic                       consume_i,
  output logic                       grant_o
);

  logic [`TLP_TX_HDR_CRED_W-1:0]  hdr_limit;
  logic [`TLP_TX_DATA_CRED_W-1:0] data_limit;
  logic [`TLP_TX_HDR_CRED_W-1:0]  hdr_used;
  logic [`TLP_TX_DATA_CRED_W-1:0] data_used;
  logic [`TLP_TX_HDR_CRED_W-1:0]  hdr_avail;
  logic [`TLP_TX_DATA_CRED_W-1:0] data_avail;
  logic                           addressed;

  // counters wrap, so the difference is taken modulo the width
  assign hdr_avail  = hdr_limit - hdr_used;
  assign data_avail = data_limit - data_used;
  assign addressed  = (req_i.cls == class_id_i);

  assign grant_o = addressed &&
                   (hdr_avail >= req_i.hdr_need) &&
                   (data_avail >= req_i.data_need);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hdr_limit  <= '0;
      data_limit <= '0;
    end else if (limit_valid_i) begin
      hdr_limit  <= limit_i.hdr_limit;
      data_limit <= limit_i.data_limit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hdr_used  <= '0;
      data_used <= '0;
    end else if (consume_i && grant_o) begin
      // only the gate that granted pays for the TLP
      hdr_used  <= hdr_used + req_i.hdr_need;
      data_used <= data_used + req_i.data_need;
    end
  end

  // the framer only consumes what this gate has granted
  a_consume_granted: assert property (@(posedge clk_i) disable iff (rst_i)
    consume_i && addressed |-> grant_o);

endmodule

// ==== design/lcrc_engine.sv ====
// 32-bit LCRC accumulator, one whole word folded in per update, MSB first.
// Clear reloads the seed before each TLP.
`timescale 1ns/10ps
`include "tlp_tx_settings.svh"

module lcrc_engine (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      clear_i,
  input  logic                      update_i,
  input  logic [`TLP_TX_DATA_W-1:0] word_i,
  output logic [31:0]               crc_o
);

  logic [31:0] crc_r;

  function automatic logic [31:0] fold_word(input logic [31:0] crc,
                                            input logic [`TLP_TX_DATA_W-1:0] word);
    logic [31:0] acc;
    logic        fb;
    acc = crc;
    for (int i = `TLP_TX_DATA_W - 1; i >= 0; i--) begin
      fb  = acc[31] ^ word[i];
      acc = {acc[30:0], 1'b0};
      if (fb) begin
        acc = acc ^ `TLP_TX_LCRC_POLY;
      end
    end
    return acc;
  endfunction

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      crc_r <= `TLP_TX_LCRC_INIT;
    end else if (update_i) begin
      crc_r <= fold_word(crc_r, word_i);
    end
  end

  assign crc_o = crc_r;

endmodule

// ==== design/dllp_framer.sv ====
// Framing FSM for the transmit data link layer.
// Waits for credit, then sends the sequence word, the TLP words unchanged
// and the inverted LCRC, and advances the sequence number per TLP.
`timescale 1ns/10ps
`include "tlp_tx_settings.svh"

module dllp_framer (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  tlp_tx_pkg::tlp_beat_t          head_beat_i,
  input  logic                           head_valid_i,
  output logic                           head_ready_o,
  input  logic [`TLP_TX_NUM_CLASSES-1:0] grant_i,
  output logic                           consume_o,
  output logic                           crc_clear_o,
  output logic                           crc_update_o,
  output logic [`TLP_TX_DATA_W-1:0]      crc_word_o,
  input  logic [31:0]                    crc_i,
  output tlp_tx_pkg::link_beat_t         out_beat_o,
  output logic                           out_valid_o,
  input  logic                           out_ready_i,
  output logic [`TLP_TX_SEQ_W-1:0]       seq_num_o
);

  typedef enum logic [1:0] {
    ST_HDR_WAIT,
    ST_SEQ,
    ST_STREAM,
    ST_LCRC
  } state_e;

  state_e                    state_r;
  state_e                    state_nxt;
  logic [`TLP_TX_SEQ_W-1:0]  seq_r;
  logic                      seq_adv;
  logic [`TLP_TX_DATA_W-1:0] seq_word;
  logic                      sop_fire;
  logic                      eop_fire;

  // upper bits of the sequence word are reserved zero
  assign seq_word  = {{(`TLP_TX_DATA_W-`TLP_TX_SEQ_W){1'b0}}, seq_r};
  assign seq_num_o = seq_r;
  assign sop_fire  = out_valid_o && out_ready_i && out_beat_o.sop;
  assign eop_fire  = out_valid_o && out_ready_i && out_beat_o.eop;

  always_comb begin
    state_nxt       = state_r;
    head_ready_o    = 1'b0;
    consume_o       = 1'b0;
    crc_clear_o     = 1'b0;
    crc_update_o    = 1'b0;
    crc_word_o      = head_beat_i.data;
    seq_adv         = 1'b0;
    out_valid_o     = 1'b0;
    out_beat_o      = '0;
    out_beat_o.data = head_beat_i.data;
    case (state_r)
      ST_HDR_WAIT: begin
        if (head_valid_i && |grant_i) begin
          consume_o   = 1'b1;
          crc_clear_o = 1'b1;
          state_nxt   = ST_SEQ;
        end
      end
      ST_SEQ: begin
        out_valid_o     = 1'b1;
        out_beat_o.sop  = 1'b1;
        out_beat_o.data = seq_word;
        crc_word_o      = seq_word;
        if (out_ready_i) begin
          crc_update_o = 1'b1;
          state_nxt    = ST_STREAM;
        end
      end
      ST_STREAM: begin
        out_valid_o  = head_valid_i;
        head_ready_o = out_ready_i;
        if (head_valid_i && out_ready_i) begin
          crc_update_o = 1'b1;
          if (head_beat_i.last) begin
            state_nxt = ST_LCRC;
          end
        end
      end
      ST_LCRC: begin
        out_valid_o     = 1'b1;
        out_beat_o.eop  = 1'b1;
        out_beat_o.data = ~crc_i;
        if (out_ready_i) begin
          seq_adv   = 1'b1;
          state_nxt = ST_HDR_WAIT;
        end
      end
      default: state_nxt = ST_HDR_WAIT;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= ST_HDR_WAIT;
      seq_r   <= '0;
    end else begin
      state_r <= state_nxt;
      if (seq_adv) begin
        seq_r <= seq_r + 1'b1;
      end
    end
  end

  // no second sop before the open packet is closed
  a_sop_eop: assert property (@(posedge clk_i) disable iff (rst_i)
    sop_fire |=> !sop_fire until eop_fire);

  a_state_known: assert property (@(posedge clk_i) disable iff (rst_i)
    !$isunknown(state_r));

endmodule

// ==== design/tlp_tx_top.sv ====
// Transmit data link layer top level.
// Input skid, class decode, per-class credit gates, framer with LCRC,
// and an output skid toward the link.
`timescale 1ns/10ps
`include "tlp_tx_settings.svh"

module tlp_tx_top (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  tlp_tx_pkg::tlp_beat_t         s_beat_i,
  input  logic                          s_valid_i,
  output logic                          s_ready_o,
  output tlp_tx_pkg::link_beat_t        m_beat_o,
  output logic                          m_valid_o,
  input  logic                          m_ready_i,
  input  tlp_tx_pkg::fc_update_t        fc_update_i,
  input  logic                          fc_update_valid_i,
  output logic [`TLP_TX_SEQ_W-1:0]      seq_num_o
);

  tlp_tx_pkg::tlp_beat_t           head_beat;
  logic                            head_valid;
  logic                            head_ready;
  tlp_tx_pkg::tlp_hdr_dw0_t        head_word;
  tlp_tx_pkg::credit_req_t         credit_req;
  logic [`TLP_TX_NUM_CLASSES-1:0]  grant;
  logic                            consume;
  logic                            crc_clear;
  logic                            crc_update;
  logic [`TLP_TX_DATA_W-1:0]       crc_word;
  logic [31:0]                     crc;
  tlp_tx_pkg::link_beat_t          link_beat;
  logic                            link_valid;
  logic                            link_ready;

  assign head_word = head_beat.data;

  beat_skid #(.beat_t(tlp_tx_pkg::tlp_beat_t)) in_skid_inst (
    .clk_i(clk_i), .rst_i(rst_i),
    .in_beat_i(s_beat_i), .in_valid_i(s_valid_i), .in_ready_o(s_ready_o),
    .out_beat_o(head_beat), .out_valid_o(head_valid), .out_ready_i(head_ready)
  );

  tlp_classifier tlp_classifier_inst (.head_word_i(head_word), .req_o(credit_req));

  for (genvar i = 0; i < `TLP_TX_NUM_CLASSES; i++) begin : g_gate
    credit_gate credit_gate_inst (
      .clk_i(clk_i), .rst_i(rst_i),
      .class_id_i(tlp_tx_pkg::credit_class_e'(i)), .req_i(credit_req),
      .limit_i(fc_update_i[i]), .limit_valid_i(fc_update_valid_i),
      .consume_i(consume), .grant_o(grant[i])
    );
  end

  lcrc_engine lcrc_engine_inst (
    .clk_i(clk_i), .rst_i(rst_i), .clear_i(crc_clear), .update_i(crc_update),
    .word_i(crc_word), .crc_o(crc)
  );

  dllp_framer dllp_framer_inst (
    .clk_i(clk_i), .rst_i(rst_i),
    .head_beat_i(head_beat), .head_valid_i(head_valid), .head_ready_o(head_ready),
    .grant_i(grant), .consume_o(consume),
    .crc_clear_o(crc_clear), .crc_update_o(crc_update), .crc_word_o(crc_word), .crc_i(crc),
    .out_beat_o(link_beat), .out_valid_o(link_valid), .out_ready_i(link_ready),
    .seq_num_o(seq_num_o)
  );

  beat_skid #(.beat_t(tlp_tx_pkg::link_beat_t)) out_skid_inst (
    .clk_i(clk_i), .rst_i(rst_i),
    .in_beat_i(link_beat), .in_valid_i(link_valid), .in_ready_o(link_ready),
    .out_beat_o(m_beat_o), .out_valid_o(m_valid_o), .out_ready_i(m_ready_i)
  );

endmodule

// ==== bench/tb_clock_gen.sv ====
// Clock and reset source for the TLP transmit bench.
// Reset is held high for a fixed number of rising edges.
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int HALF_PERIOD_NS = 4,
  parameter int RST_CYCLES     = 5
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    rst_o = 1'b1;
  end

  always #(HALF_PERIOD_NS) clk_o = ~clk_o;

  initial begin
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

// ==== bench/tlp_tx_tb.sv ====
// Bench for the transmit data link layer top level.
// Builds TLPs, predicts the framed output with its own CRC and credit
// model, and checks the link stream with concurrent assertions.
`timescale 1ns/10ps
`include "tlp_tx_settings.svh"

module tlp_tx_tb;

  localparam int NUM_WRAP   = 4097;
  localparam int MAX_CYCLES = (NUM_WRAP + 40) * 24 + 4000;

  logic                          clk_i;
  logic                          rst_i;
  tlp_tx_pkg::tlp_beat_t         s_beat_i;
  logic                          s_valid_i;
  logic                          s_ready_o;
  tlp_tx_pkg::link_beat_t        m_beat_o;
  logic                          m_valid_o;
  logic                          m_ready_i;
  tlp_tx_pkg::fc_update_t        fc_update_i;
  logic                          fc_update_valid_i;
  logic [`TLP_TX_SEQ_W-1:0]      seq_num_o;

  // expected link beats and queued input beats
  logic [33:0] exp_mem [32768];
  logic [32:0] in_mem [32768];
  int          exp_rd;
  int          exp_wr;
  int          in_rd;
  int          in_wr;
  logic [33:0] exp_head;
  int          done_cnt;
  int          err_cnt;
  int          cycle_cnt;
  int          sent_cnt;
  logic        hold_idle;
  logic [11:0] seq_model;
  logic [11:0] next_seq;
  logic [31:0] main_seed;
  logic [31:0] rdy_seed;
  logic [31:0] gap_seed;

  // credit model, per class
  logic [`TLP_TX_HDR_CRED_W-1:0]  used_h [3];
  logic [`TLP_TX_DATA_CRED_W-1:0] used_d [3];
  logic [`TLP_TX_HDR_CRED_W-1:0]  lim_h [3];
  logic [`TLP_TX_DATA_CRED_W-1:0] lim_d [3];

  tb_clock_gen clock_gen_inst (.clk_o(clk_i), .rst_o(rst_i));

  tlp_tx_top tlp_tx_top_inst (
    .clk_i(clk_i), .rst_i(rst_i),
    .s_beat_i(s_beat_i), .s_valid_i(s_valid_i), .s_ready_o(s_ready_o),
    .m_beat_o(m_beat_o), .m_valid_o(m_valid_o), .m_ready_i(m_ready_i),
    .fc_update_i(fc_update_i), .fc_update_valid_i(fc_update_valid_i),
    .seq_num_o(seq_num_o)
  );

  assign exp_head = exp_mem[exp_rd[14:0]];
  assign next_seq = 12'(done_cnt + 1);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // CRC-32, MSB of the word first
  function automatic logic [31:0] crc_fold(input logic [31:0] c, input logic [31:0] w);
    logic [31:0] r;
    r = c;
    for (int b = 31; b >= 0; b--) begin
      if (r[31] != w[b]) begin
        r = (r << 1) ^ `TLP_TX_LCRC_POLY;
      end else begin
        r = r << 1;
      end
    end
    return r;
  endfunction

  function automatic int class_of(input logic [2:0] fmt, input logic [4:0] typ);
    if (typ == 5'b01010) begin
      return 2;
    end
    if (typ[4:3] == 2'b10 || (typ == 5'b00000 && fmt[1])) begin
      return 0;
    end
    return 1;
  endfunction

  function automatic int data_credits(input logic [2:0] fmt, input logic [9:0] len);
    int dw;
    if (!fmt[1]) begin
      return 0;
    end
    dw = (len == 10'd0) ? 1024 : int'(len);
    return (dw + 3) / 4;
  endfunction

  function automatic logic [31:0] make_dw0(input logic [2:0] fmt, input logic [4:0] typ,
                                           input logic [9:0] len);
    return {fmt, typ, 14'h0a5, len};
  endfunction

  task automatic apply_limits();
    for (int c = 0; c < 3; c++) begin
      fc_update_i[c].hdr_limit  = lim_h[c];
      fc_update_i[c].data_limit = lim_d[c];
    end
    fc_update_valid_i = 1'b1;
    @(posedge clk_i);
    #1 fc_update_valid_i = 1'b0;
  endtask

  task automatic push_expected(input logic sop, input logic eop, input logic [31:0] w);
    exp_mem[exp_wr[14:0]] = {sop, eop, w};
    exp_wr++;
  endtask

  task automatic push_input(input logic last, input logic [31:0] w);
    in_mem[in_wr[14:0]] = {last, w};
    in_wr++;
  endtask

  // queue one TLP; auto_credit advertises exactly what it needs
  task automatic send_tlp(input logic [31:0] dw0, input bit auto_credit);
    int          cls;
    int          nwords;
    logic [31:0] crc;
    logic [31:0] w;
    cls = class_of(dw0[31:29], dw0[28:24]);
    used_h[cls] = used_h[cls] + 1'b1;
    used_d[cls] = used_d[cls] + 12'(data_credits(dw0[31:29], dw0[9:0]));
    if (auto_credit) begin
      lim_h[cls] = used_h[cls];
      lim_d[cls] = used_d[cls];
      apply_limits();
    end
    nwords = 3;
    if (dw0[30]) begin
      nwords += (dw0[9:0] == 10'd0) ? 1024 : int'(dw0[9:0]);
    end
    crc = crc_fold(`TLP_TX_LCRC_INIT, {20'h0, seq_model});
    push_expected(1'b1, 1'b0, {20'h0, seq_model});
    seq_model = seq_model + 1'b1;
    for (int i = 0; i < nwords; i++) begin
      main_seed = lcg_next(main_seed);
      w = (i == 0) ? dw0 : main_seed;
      crc = crc_fold(crc, w);
      push_expected(1'b0, 1'b0, w);
      push_input(i == nwords - 1, w);
    end
    push_expected(1'b0, 1'b1, ~crc);
    sent_cnt++;
  endtask

  task automatic send_random(input int count);
    logic [9:0] len;
    for (int n = 0; n < count; n++) begin
      main_seed = lcg_next(main_seed);
      len = 10'(main_seed[19:16]) + 10'd1;
      case (main_seed[26:24] % 5)
        0: send_tlp(make_dw0(3'b000, 5'b00000, len), 1'b1);
        1: send_tlp(make_dw0(3'b010, 5'b00000, len), 1'b1);
        2: send_tlp(make_dw0(3'b001, 5'b10011, len), 1'b1);
        3: send_tlp(make_dw0(3'b000, 5'b01010, len), 1'b1);
        default: send_tlp(make_dw0(3'b010, 5'b01010, len), 1'b1);
      endcase
    end
  endtask

  task automatic wait_done(input int target);
    while (done_cnt < target) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // the blocked TLP fills the input skid, so its ready must be low
  task automatic expect_idle(input int cycles);
    hold_idle = 1'b1;
    repeat (cycles) @(posedge clk_i);
    #1 hold_idle = 1'b0;
    a_input_full: assert (!s_ready_o)
      else begin
        err_cnt++;
        $display("ERR %0t s_ready_o expected 0 actual %b", $time, s_ready_o);
      end
  endtask

  initial begin
    s_beat_i          = '0;
    s_valid_i         = 1'b0;
    m_ready_i         = 1'b0;
    fc_update_i       = '0;
    fc_update_valid_i = 1'b0;
    exp_wr    = 0;
    in_wr     = 0;
    sent_cnt  = 0;
    hold_idle = 1'b0;
    seq_model = '0;
    main_seed = 32'he342;
    for (int c = 0; c < 3; c++) begin
      used_h[c] = '0;
      used_d[c] = '0;
      lim_h[c]  = '0;
      lim_d[c]  = '0;
    end
    wait (!rst_i);
    @(posedge clk_i);
    #1;

    // no credit after reset, then the read is released
    send_tlp(make_dw0(3'b000, 5'b00000, 10'd1), 1'b0);
    expect_idle(50);
    lim_h[1] = used_h[1];
    apply_limits();
    wait_done(sent_cnt);

    send_random(24);
    wait_done(sent_cnt);

    // 9 DW write needs 3 data credits, only 2 given
    send_tlp(make_dw0(3'b010, 5'b00000, 10'd9), 1'b0);
    lim_h[0] = used_h[0];
    lim_d[0] = used_d[0] - 12'd1;
    apply_limits();
    send_tlp(make_dw0(3'b001, 5'b00000, 10'd1), 1'b1);
    expect_idle(50);
    lim_d[0] = used_d[0];
    apply_limits();
    wait_done(sent_cnt);

    // non-posted exhausted, other classes still flow
    send_tlp(make_dw0(3'b010, 5'b00000, 10'd4), 1'b1);
    send_tlp(make_dw0(3'b000, 5'b01010, 10'd1), 1'b1);
    send_tlp(make_dw0(3'b010, 5'b01010, 10'd5), 1'b1);
    send_tlp(make_dw0(3'b001, 5'b10000, 10'd0), 1'b1);
    wait_done(sent_cnt);
    send_tlp(make_dw0(3'b000, 5'b00000, 10'd2), 1'b0);
    expect_idle(50);
    lim_h[1] = used_h[1];
    apply_limits();
    wait_done(sent_cnt);

    // enough short messages to wrap the sequence number
    for (int n = 0; n < NUM_WRAP; n++) begin
      send_tlp(make_dw0(3'b001, 5'b10000, 10'd0), 1'b1);
      // outstanding posted headers stay within the 8-bit credit range
      if (sent_cnt - done_cnt >= 64) begin
        wait_done(sent_cnt - 32);
      end
    end
    wait_done(sent_cnt);

    $display("run done: %0d packets, %0d errors", done_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // input driver, gaps between TLPs
  initial begin
    logic rdy;
    in_rd    = 0;
    gap_seed = lcg_next(32'he342);
    wait (!rst_i);
    @(posedge clk_i);
    #1;
    forever begin
      if (in_rd != in_wr) begin
        s_beat_i  = in_mem[in_rd[14:0]];
        s_valid_i = 1'b1;
        rdy = s_ready_o;
        @(posedge clk_i);
        #1;
        if (rdy) begin
          in_rd++;
          s_valid_i = 1'b0;
          if (s_beat_i.last) begin
            gap_seed = lcg_next(gap_seed);
            repeat (gap_seed[17:16] % 3) begin
              @(posedge clk_i);
              #1;
            end
          end
        end
      end else begin
        @(posedge clk_i);
        #1;
      end
    end
  end

  // output back-pressure, ready about 3 of 4 cycles
  initial begin
    rdy_seed = lcg_next(lcg_next(32'he342));
    forever begin
      @(posedge clk_i);
      #1;
      rdy_seed  = lcg_next(rdy_seed);
      m_ready_i = (rdy_seed[21:20] != 2'b00);
    end
  end

  always @(posedge clk_i) begin
    if (rst_i) begin
      exp_rd   <= 0;
      done_cnt <= 0;
    end else if (m_valid_o && m_ready_i) begin
      exp_rd <= exp_rd + 1;
      if (m_beat_o.eop) begin
        done_cnt <= done_cnt + 1;
      end
    end
  end

  initial err_cnt = 0;

  always @(posedge clk_i) begin
    if (rst_i) begin
      cycle_cnt <= 0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > MAX_CYCLES) begin
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
      end
    end
  end

  a_beat_value: assert property (@(posedge clk_i) disable iff (rst_i)
    m_valid_o && m_ready_i |-> m_beat_o == exp_head)
    else begin
      err_cnt++;
      $display("ERR %0t m_beat_o expected %h actual %h", $time,
               $sampled(exp_head), $sampled(m_beat_o));
    end

  a_no_extra: assert property (@(posedge clk_i) disable iff (rst_i)
    m_valid_o && m_ready_i |-> exp_rd != exp_wr)
    else begin
      err_cnt++;
      $display("%0t: an output beat arrived with nothing expected", $time);
    end

  a_held: assert property (@(posedge clk_i) disable iff (rst_i)
    m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_beat_o))
    else begin
      err_cnt++;
      $display("%0t: m_beat_o changed while stalled", $time);
    end

  a_blocked: assert property (@(posedge clk_i) disable iff (rst_i)
    hold_idle |-> !m_valid_o)
    else begin
      err_cnt++;
      $display("%0t: output appeared while credit was missing", $time);
    end

  a_seq_after_eop: assert property (@(posedge clk_i) disable iff (rst_i)
    m_valid_o && m_ready_i && m_beat_o.eop |-> seq_num_o == next_seq)
    else begin
      err_cnt++;
      $display("ERR %0t seq_num_o expected %h actual %h", $time,
               $sampled(next_seq), $sampled(seq_num_o));
    end

endmodule

// ==== flist.f ====
+incdir+design
design/tlp_tx_pkg.sv
design/beat_skid.sv
design/tlp_classifier.sv
design/credit_gate.sv
design/lcrc_engine.sv
design/dllp_framer.sv
design/tlp_tx_top.sv
bench/tb_clock_gen.sv
bench/tlp_tx_tb.sv

// ==== Makefile ====
TOP := tlp_tx_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

obj_dir/V$(TOP): flist.f design/*.sv design/*.svh bench/*.sv
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
